// ==== src/async_fifo_pkg.sv ====
package async_fifo_pkg;

    // FIFO sizing
    localparam int DATA_WIDTH  = 8;
    localparam int FIFO_DEPTH  = 16;
    localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH);
    // One extra wrap bit tells full from empty
    localparam int PTR_WIDTH   = ADDR_WIDTH + 1;
    localparam int NUM_SYNC_FF = 2;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // Pointer layout, binary or Gray
    typedef struct packed {
        logic                  wrap;
        logic [ADDR_WIDTH-1:0] addr;
    } fifo_ptr_t;

    function automatic fifo_ptr_t bin_to_gray(input fifo_ptr_t bin);
        logic [PTR_WIDTH-1:0] b;
        b = bin;
        return b ^ (b >> 1);
    endfunction

    // Prefix XOR from the top bit down
    function automatic fifo_ptr_t gray_to_bin(input fifo_ptr_t gray);
        logic [PTR_WIDTH-1:0] g;
        logic [PTR_WIDTH-1:0] b;
        g = gray;
        b[PTR_WIDTH-1] = g[PTR_WIDTH-1];
        for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

endpackage

// ==== src/fifo_mem.sv ====
`timescale 1ns/1ps

module fifo_mem (
    input  logic                                 clk_wr_domain,
    input  logic                                 wr_en_i,
    input  logic [async_fifo_pkg::ADDR_WIDTH-1:0] wr_addr_i,
    input  async_fifo_pkg::data_t                wr_data_i,
    input  logic [async_fifo_pkg::ADDR_WIDTH-1:0] rd_addr_i,
    output async_fifo_pkg::data_t                rd_data_o
);
    import async_fifo_pkg::*;

    // Storage array, no reset
    data_t mem_q [FIFO_DEPTH];

    // Write port on the write clock
    always_ff @(posedge clk_wr_domain) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Head word is visible without a read strobe
    assign rd_data_o = mem_q[rd_addr_i];

endmodule

// ==== src/fifo_wr_ctrl.sv ====
`timescale 1ns/1ps

module fifo_wr_ctrl (
    input  logic                                  clk_wr_domain,
    input  logic                                  rst_n,
    input  logic                                  wr_valid_i,
    // Read pointer, binary, already in this domain
    input  async_fifo_pkg::fifo_ptr_t             rd_ptr_i,
    output logic                                  wr_en_o,
    output logic [async_fifo_pkg::ADDR_WIDTH-1:0] wr_addr_o,
    output async_fifo_pkg::fifo_ptr_t             wr_ptr_gray_o,
    output logic                                  wr_ready_o,
    output logic                                  full_o,
    output logic                                  almost_full_o
);
    import async_fifo_pkg::*;

    fifo_ptr_t             wr_ptr_q;
    fifo_ptr_t             wr_ptr_inc;
    logic [ADDR_WIDTH-1:0] wr_addr_inc;
    logic [PTR_WIDTH-1:0]  wr_level;

    assign wr_ptr_inc  = wr_ptr_q + 1'b1;
    assign wr_addr_inc = wr_ptr_q.addr + 1'b1;

    // Words in flight as seen from the write side
    assign wr_level = wr_ptr_q - rd_ptr_i;

    // Same slot, other lap
    assign full_o        = (wr_ptr_q.addr == rd_ptr_i.addr) &&
                           (wr_ptr_q.wrap != rd_ptr_i.wrap);
    // One free slot left
    assign almost_full_o = (wr_addr_inc == rd_ptr_i.addr);

    assign wr_ready_o = ~full_o;
    assign wr_en_o    = wr_valid_i & wr_ready_o;
    assign wr_addr_o  = wr_ptr_q.addr;

    always_ff @(posedge clk_wr_domain or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
        end else if (wr_en_o) begin
            wr_ptr_q <= wr_ptr_inc;
        end
    end

    // Gray copy trails the binary pointer by one cycle
    always_ff @(posedge clk_wr_domain or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_gray_o <= '0;
        end else begin
            wr_ptr_gray_o <= bin_to_gray(wr_ptr_q);
        end
    end

    // A write is only taken while the pointer distance shows room
    a_no_write_when_full : assert property (
        @(posedge clk_wr_domain) disable iff (!rst_n)
        wr_en_o |-> (wr_level < PTR_WIDTH'(FIFO_DEPTH))
    );

endmodule

// ==== src/fifo_rd_ctrl.sv ====
`timescale 1ns/1ps

module fifo_rd_ctrl (
    input  logic                                  clk_rd_domain,
    input  logic                                  rst_n,
    input  logic                                  rd_valid_i,
    // Write pointer, binary, already in this domain
    input  async_fifo_pkg::fifo_ptr_t             wr_ptr_i,
    output logic [async_fifo_pkg::ADDR_WIDTH-1:0] rd_addr_o,
    output async_fifo_pkg::fifo_ptr_t             rd_ptr_gray_o,
    output logic                                  rd_ready_o,
    output logic                                  empty_o,
    output logic                                  almost_empty_o
);
    import async_fifo_pkg::*;

    fifo_ptr_t rd_ptr_q;
    fifo_ptr_t rd_ptr_inc;
    logic      rd_en;

    assign rd_ptr_inc = rd_ptr_q + 1'b1;

    // Pointers equal including the wrap bit
    assign empty_o        = (rd_ptr_q == wr_ptr_i);
    // One word left to read
    assign almost_empty_o = (rd_ptr_inc == wr_ptr_i);

    assign rd_ready_o = ~empty_o;
    assign rd_en      = rd_valid_i & rd_ready_o;
    assign rd_addr_o  = rd_ptr_q.addr;

    always_ff @(posedge clk_rd_domain or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
        end else if (rd_en) begin
            rd_ptr_q <= rd_ptr_inc;
        end
    end

    // Registered Gray form for the crossing
    always_ff @(posedge clk_rd_domain or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_gray_o <= '0;
        end else begin
            rd_ptr_gray_o <= bin_to_gray(rd_ptr_q);
        end
    end

    // The crossing relies on a single bit flip per read clock
    a_gray_one_bit : assert property (
        @(posedge clk_rd_domain) disable iff (!rst_n)
        $countones(rd_ptr_gray_o ^ $past(rd_ptr_gray_o)) <= 1
    );

endmodule

// ==== src/ptr_sync.sv ====
`timescale 1ns/1ps

module ptr_sync (
    // Destination domain clock
    input  logic                      clk_i,
    input  logic                      rst_n,
    input  async_fifo_pkg::fifo_ptr_t ptr_gray_i,
    output async_fifo_pkg::fifo_ptr_t ptr_bin_o
);
    import async_fifo_pkg::*;

    // Stage 0 may go metastable, the last stage is stable
    fifo_ptr_t [NUM_SYNC_FF-1:0] sync_q;

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= ptr_gray_i;
            for (int i = 1; i < NUM_SYNC_FF; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Back to binary for the flag compare
    assign ptr_bin_o = gray_to_bin(sync_q[NUM_SYNC_FF-1]);

    // Synchronized pointer only moves forward, never by more than one lap
    a_sync_step : assert property (
        @(posedge clk_i) disable iff (!rst_n)
        PTR_WIDTH'(ptr_bin_o - $past(ptr_bin_o)) <= PTR_WIDTH'(FIFO_DEPTH)
    );

endmodule

// ==== src/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
    input  logic                  clk_wr_domain,
    input  logic                  clk_rd_domain,
    input  logic                  rst_n,
    input  async_fifo_pkg::data_t data_i,
    input  logic                  wr_valid_i,
    input  logic                  rd_valid_i,
    output async_fifo_pkg::data_t data_o,
    output logic                  wr_ready_o,
    output logic                  rd_ready_o,
    output logic                  full_o,
    output logic                  empty_o,
    output logic                  almost_full_o,
    output logic                  almost_empty_o
);
    import async_fifo_pkg::*;

    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [ADDR_WIDTH-1:0] rd_addr;
    // Gray pointers leaving each domain
    fifo_ptr_t             wr_ptr_gray;
    fifo_ptr_t             rd_ptr_gray;
    // Binary pointers after the crossing
    fifo_ptr_t             wr_ptr_sync;
    fifo_ptr_t             rd_ptr_sync;

    fifo_mem i_mem (
        .clk_wr_domain (clk_wr_domain),
        .wr_en_i       (wr_en),
        .wr_addr_i     (wr_addr),
        .wr_data_i     (data_i),
        .rd_addr_i     (rd_addr),
        .rd_data_o     (data_o)
    );

    fifo_wr_ctrl i_wr_ctrl (
        .clk_wr_domain (clk_wr_domain),
        .rst_n         (rst_n),
        .wr_valid_i    (wr_valid_i),
        .rd_ptr_i      (rd_ptr_sync),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr),
        .wr_ptr_gray_o (wr_ptr_gray),
        .wr_ready_o    (wr_ready_o),
        .full_o        (full_o),
        .almost_full_o (almost_full_o)
    );

    fifo_rd_ctrl i_rd_ctrl (
        .clk_rd_domain  (clk_rd_domain),
        .rst_n          (rst_n),
        .rd_valid_i     (rd_valid_i),
        .wr_ptr_i       (wr_ptr_sync),
        .rd_addr_o      (rd_addr),
        .rd_ptr_gray_o  (rd_ptr_gray),
        .rd_ready_o     (rd_ready_o),
        .empty_o        (empty_o),
        .almost_empty_o (almost_empty_o)
    );

    // Write pointer into the read domain
    ptr_sync i_sync_wr2rd (
        .clk_i      (clk_rd_domain),
        .rst_n      (rst_n),
        .ptr_gray_i (wr_ptr_gray),
        .ptr_bin_o  (wr_ptr_sync)
    );

    // Read pointer into the write domain
    ptr_sync i_sync_rd2wr (
        .clk_i      (clk_wr_domain),
        .rst_n      (rst_n),
        .ptr_gray_i (rd_ptr_gray),
        .ptr_bin_o  (rd_ptr_sync)
    );

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    // Free-running clock, low for the first half period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

// ==== verif/tb_async_fifo.sv ====
`timescale 1ns/1ps

module tb_async_fifo;
    import async_fifo_pkg::*;

    localparam int unsigned LCG_SEED   = 17;
    localparam int          RAND_WORDS = 200;
    localparam int          RAND_TOTAL = FIFO_DEPTH + RAND_WORDS;
    localparam int          RAND_HALF  = FIFO_DEPTH + RAND_WORDS / 2;
    // About 16 write cycles per word at the slowest valid rate, plus reset and settling
    localparam int          MAX_CYCLES = (2 * FIFO_DEPTH + RAND_WORDS) * 16 + 200;

    logic        clk_wr_domain;
    logic        clk_rd_domain;
    logic        rst_n;
    data_t       data_i;
    logic        wr_valid_i;
    logic        rd_valid_i;
    data_t       data_o;
    logic        wr_ready_o;
    logic        rd_ready_o;
    logic        full_o;
    logic        empty_o;
    logic        almost_full_o;
    logic        almost_empty_o;

    int          wr_accepted;
    int          rd_accepted;
    int          wr_stalls;
    int          rd_stalls;
    int          value_errors;
    int          other_errors;
    int          cycle_count;
    bit          in_random;
    string       read_test;
    int unsigned wr_data_state;
    int unsigned wr_rng;
    int unsigned rd_rng;

    tb_clk_gen #(.PERIOD_NS(20.0)) i_clk_wr (.clk_o(clk_wr_domain));
    tb_clk_gen #(.PERIOD_NS(28.0)) i_clk_rd (.clk_o(clk_rd_domain));

    async_fifo i_dut (
        .clk_wr_domain  (clk_wr_domain),
        .clk_rd_domain  (clk_rd_domain),
        .rst_n          (rst_n),
        .data_i         (data_i),
        .wr_valid_i     (wr_valid_i),
        .rd_valid_i     (rd_valid_i),
        .data_o         (data_o),
        .wr_ready_o     (wr_ready_o),
        .rd_ready_o     (rd_ready_o),
        .full_o         (full_o),
        .empty_o        (empty_o),
        .almost_full_o  (almost_full_o),
        .almost_empty_o (almost_empty_o)
    );

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Order is preserved, so the nth word read is the nth LCG word
    function automatic data_t expected_word(input int index);
        int unsigned state;
        state = LCG_SEED;
        for (int n = 0; n <= index; n++) begin
            state = lcg_next(state);
        end
        return state[23:16];
    endfunction

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        value_errors++;
        $display("ERR %s expected %0h actual %0h", test_name, expected, actual);
    endtask

    task automatic drive_write(input logic valid);
        wr_valid_i = valid;
        data_i     = wr_data_state[23:16];
    endtask

    task automatic write_until(input int target);
        @(negedge clk_wr_domain);
        while (wr_accepted < target) begin
            drive_write(1'b1);
            @(negedge clk_wr_domain);
        end
        drive_write(1'b0);
    endtask

    task automatic read_until(input int target);
        @(negedge clk_rd_domain);
        while (rd_accepted < target) begin
            rd_valid_i = 1'b1;
            @(negedge clk_rd_domain);
        end
        rd_valid_i = 1'b0;
    endtask

    // Write acceptance seen at the edge, before the DUT registers update
    always @(posedge clk_wr_domain) begin
        if (rst_n && wr_valid_i && wr_ready_o) begin
            wr_accepted++;
            wr_data_state = lcg_next(wr_data_state);
        end
        if (in_random && wr_valid_i && !wr_ready_o) begin
            wr_stalls++;
        end
    end

    // Compare every accepted read with the reference
    always @(posedge clk_rd_domain) begin
        if (rst_n && rd_valid_i && rd_ready_o) begin
            if (data_o !== expected_word(rd_accepted)) begin
                report_mismatch(read_test, expected_word(rd_accepted), data_o);
            end
            rd_accepted++;
        end
        if (in_random && rd_valid_i && !rd_ready_o) begin
            rd_stalls++;
        end
    end

    always @(posedge clk_wr_domain) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d write cycles, %0d writes and %0d reads done",
                     cycle_count, wr_accepted, rd_accepted);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        rst_n         = 1'b0;
        data_i        = '0;
        wr_valid_i    = 1'b0;
        rd_valid_i    = 1'b0;
        wr_accepted   = 0;
        rd_accepted   = 0;
        wr_stalls     = 0;
        rd_stalls     = 0;
        value_errors  = 0;
        other_errors  = 0;
        cycle_count   = 0;
        in_random     = 1'b0;
        read_test     = "drain";
        wr_data_state = lcg_next(LCG_SEED);
        wr_rng        = LCG_SEED ^ 32'h0000_A5A5;
        rd_rng        = LCG_SEED ^ 32'h5A5A_0000;

        repeat (8) @(negedge clk_wr_domain);
        rst_n = 1'b1;
        if (empty_o !== 1'b1) report_mismatch("reset empty_o", 1, empty_o);
        if (rd_ready_o !== 1'b0) report_mismatch("reset rd_ready_o", 0, rd_ready_o);
        if (full_o !== 1'b0) report_mismatch("reset full_o", 0, full_o);
        if (wr_ready_o !== 1'b1) report_mismatch("reset wr_ready_o", 1, wr_ready_o);
        if (almost_full_o !== 1'b0) report_mismatch("reset almost_full_o", 0, almost_full_o);
        if (almost_empty_o !== 1'b0) report_mismatch("reset almost_empty_o", 0, almost_empty_o);

        // Fill with no reads, one slot short first
        write_until(FIFO_DEPTH - 1);
        repeat (4) @(negedge clk_wr_domain);
        if (almost_full_o !== 1'b1) report_mismatch("fill almost_full_o", 1, almost_full_o);
        if (full_o !== 1'b0) report_mismatch("fill full_o early", 0, full_o);
        while (wr_ready_o === 1'b1) begin
            drive_write(1'b1);
            @(negedge clk_wr_domain);
        end
        if (wr_accepted != FIFO_DEPTH) report_mismatch("fill count", FIFO_DEPTH, wr_accepted);
        // Valid stays high against a full FIFO
        repeat (6) begin
            @(negedge clk_wr_domain);
            if (full_o !== 1'b1) report_mismatch("fill full_o held", 1, full_o);
        end
        drive_write(1'b0);
        if (wr_accepted != FIFO_DEPTH) report_mismatch("fill overrun", FIFO_DEPTH, wr_accepted);

        // Drain with no writes
        read_until(FIFO_DEPTH - 1);
        repeat (4) @(negedge clk_rd_domain);
        if (almost_empty_o !== 1'b1) report_mismatch("drain almost_empty_o", 1, almost_empty_o);
        read_until(FIFO_DEPTH);
        if (empty_o !== 1'b1) report_mismatch("drain empty_o", 1, empty_o);
        if (rd_ready_o !== 1'b0) report_mismatch("drain rd_ready_o", 0, rd_ready_o);
        rd_valid_i = 1'b1;
        repeat (6) @(negedge clk_rd_domain);
        rd_valid_i = 1'b0;
        if (rd_accepted != FIFO_DEPTH) report_mismatch("drain overrun", FIFO_DEPTH, rd_accepted);

        // Random traffic, writer heavy first and reader heavy second
        read_test = "random";
        in_random = 1'b1;
        fork
            begin
                @(negedge clk_wr_domain);
                while (wr_accepted < RAND_TOTAL) begin
                    wr_rng = lcg_next(wr_rng);
                    drive_write(wr_rng[26:24] < ((wr_accepted < RAND_HALF) ? 7 : 3));
                    @(negedge clk_wr_domain);
                end
                drive_write(1'b0);
            end
            begin
                @(negedge clk_rd_domain);
                while (rd_accepted < RAND_TOTAL) begin
                    rd_rng = lcg_next(rd_rng);
                    rd_valid_i = (rd_rng[26:24] < ((rd_accepted < RAND_HALF) ? 3 : 7));
                    @(negedge clk_rd_domain);
                end
                rd_valid_i = 1'b0;
            end
        join
        in_random = 1'b0;
        // Keep asking for words so that any extra word would show up
        rd_valid_i = 1'b1;
        repeat (6) @(negedge clk_rd_domain);
        rd_valid_i = 1'b0;
        if (empty_o !== 1'b1) report_mismatch("random empty_o", 1, empty_o);
        if (rd_accepted != wr_accepted) report_mismatch("random totals", wr_accepted, rd_accepted);
        if (wr_stalls == 0) begin
            other_errors++;
            $display("No write was ever held off by a full FIFO during random traffic");
        end
        if (rd_stalls == 0) begin
            other_errors++;
            $display("No read was ever held off by an empty FIFO during random traffic");
        end

        $display("Summary: %0d value errors, %0d other errors, %0d writes, %0d reads",
                 value_errors, other_errors, wr_accepted, rd_accepted);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/async_fifo_pkg.sv
src/fifo_mem.sv
src/fifo_wr_ctrl.sv
src/fifo_rd_ctrl.sv
src/ptr_sync.sv
src/async_fifo.sv
verif/tb_clk_gen.sv
verif/tb_async_fifo.sv

// ==== Makefile ====
TOP := tb_async_fifo

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
